// File: dcache_pkg.sv
// ----------------------------------------------------------
// widths, address layout and state types of the data cache
// ----------------------------------------------------------
package dcache_pkg;

  // word and line geometry
  localparam int ADDR_WIDTH     = 32;
  localparam int WORD_WIDTH     = 32;
  localparam int BE_WIDTH       = WORD_WIDTH / 8;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
  localparam int LINE_BE_WIDTH  = LINE_WIDTH / 8;

  // address split
  localparam int OFFSET_WIDTH   = 4;
  localparam int WORD_SEL_WIDTH = 2;
  localparam int INDEX_WIDTH    = 4;
  localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

  // top half of the address space bypasses the cache
  localparam logic [ADDR_WIDTH-1:0] UNCACHED_BASE = 32'h8000_0000;

  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
  } cache_addr_s;

  // one address word, flat or split into its fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] flat;
    cache_addr_s           f;
  } cache_addr_u;

  // operations handed to the APB refill unit
  typedef enum logic [1:0] {
    OP_WRITEBACK,
    OP_REFILL,
    OP_BYPASS
  } op_kind_e;

  // request FSM
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_STORE,
    S_WRITEBACK,
    S_REFILL,
    S_REPLAY,
    S_BYPASS
  } ctrl_state_e;

endpackage

// File: dcache_array.sv
// ----------------------------------------------------------
// tag, valid, dirty and line storage with hit and victim logic
// ----------------------------------------------------------
`timescale 1ns/1ps

module dcache_array #(
  parameter int NUM_WAYS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 rd_en_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0]   rd_index_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]     lookup_tag_i,
  input  logic                                 wr_en_i,
  input  logic [NUM_WAYS-1:0]                  wr_way_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0]   wr_index_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]     wr_tag_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]    wr_line_i,
  input  logic [dcache_pkg::LINE_BE_WIDTH-1:0] wr_line_be_i,
  input  logic                                 wr_dirty_i,
  output logic                                 hit_o,
  output logic [NUM_WAYS-1:0]                  hit_way_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]    hit_line_o,
  output logic [NUM_WAYS-1:0]                  victim_way_o,
  output logic                                 victim_dirty_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]     victim_tag_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]    victim_line_o
);
  import dcache_pkg::*;

  localparam int SETS  = 2 ** INDEX_WIDTH;
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [TAG_WIDTH-1:0]               tag_q  [NUM_WAYS][SETS];
  logic [LINE_WIDTH-1:0]              line_q [NUM_WAYS][SETS];
  logic [SETS-1:0][NUM_WAYS-1:0]      valid_q;
  logic [SETS-1:0][NUM_WAYS-1:0]      dirty_q;
  logic [SETS-1:0][WAY_W-1:0]         rr_q;
  logic [INDEX_WIDTH-1:0]             idx_q;

  // read index is registered, outputs follow one cycle after rd_en
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else if (rd_en_i) begin
      idx_q <= rd_index_i;
    end
  end

  // ----------------------------------------------------------
  // hit detection
  // ----------------------------------------------------------
  always_comb begin
    hit_way_o  = '0;
    hit_line_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_q[idx_q][w] && (tag_q[w][idx_q] == lookup_tag_i)) begin
        hit_way_o[w] = 1'b1;
        hit_line_o   = hit_line_o | line_q[w][idx_q];
      end
    end
  end

  assign hit_o = |hit_way_o;

  // ----------------------------------------------------------
  // victim choice
  // ----------------------------------------------------------
  always_comb begin
    // round-robin way unless some way is still free
    victim_way_o = NUM_WAYS'(1) << rr_q[idx_q];
    // scan downwards so the lowest free way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[idx_q][w]) begin
        victim_way_o = NUM_WAYS'(1) << w;
      end
    end
    victim_dirty_o = 1'b0;
    victim_tag_o   = '0;
    victim_line_o  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim_way_o[w]) begin
        victim_dirty_o = valid_q[idx_q][w] & dirty_q[idx_q][w];
        victim_tag_o   = tag_q[w][idx_q];
        victim_line_o  = line_q[w][idx_q];
      end
    end
  end

  // state bits and replacement pointers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      rr_q    <= '0;
    end else if (wr_en_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (wr_way_i[w]) begin
          valid_q[wr_index_i][w] <= 1'b1;
          dirty_q[wr_index_i][w] <= wr_dirty_i;
        end
      end
      // a full-line write is a refill, step the pointer
      if (&wr_line_be_i) begin
        rr_q[wr_index_i] <= (rr_q[wr_index_i] == WAY_W'(NUM_WAYS - 1)) ? '0
                                                                        : rr_q[wr_index_i] + 1'b1;
      end
    end
  end

  // tag and data, bytes written under the line byte enables
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        tag_q[w][wr_index_i] <= wr_tag_i;
        for (int b = 0; b < LINE_BE_WIDTH; b++) begin
          if (wr_line_be_i[b]) begin
            line_q[w][wr_index_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // at most one way may match a tag
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_way_o));

endmodule

// File: dcache_refill.sv
// ----------------------------------------------------------
// APB master for line writeback, line refill and bypass words
// ----------------------------------------------------------
`timescale 1ns/1ps

module dcache_refill (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                op_valid_i,
  input  dcache_pkg::op_kind_e                op_kind_i,
  input  dcache_pkg::cache_addr_u             op_addr_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]   op_line_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]   op_wdata_i,
  input  logic [dcache_pkg::BE_WIDTH-1:0]     op_be_i,
  input  logic                                op_we_i,
  output logic                                op_done_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]   done_line_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]   done_word_o,
  // APB3 master
  output logic [dcache_pkg::ADDR_WIDTH-1:0]   paddr_o,
  output logic                                psel_o,
  output logic                                penable_o,
  output logic                                pwrite_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]   pwdata_o,
  output logic [dcache_pkg::BE_WIDTH-1:0]     pstrb_o,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]   prdata_i,
  input  logic                                pready_i
);
  import dcache_pkg::*;

  logic                      psel_q;
  logic                      penable_q;
  logic                      done_q;
  logic [WORD_SEL_WIDTH-1:0] cnt_q;
  logic [LINE_WIDTH-1:0]     line_q;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic                      is_bypass;
  logic                      last;

  assign is_bypass = (op_kind_i == OP_BYPASS);
  // a bypass touches one word, a line op walks all of them
  assign word_sel  = is_bypass ? op_addr_i.f.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH] : cnt_q;
  assign last      = is_bypass || (cnt_q == WORD_SEL_WIDTH'(WORDS_PER_LINE - 1));

  // ----------------------------------------------------------
  // APB outputs
  // ----------------------------------------------------------
  assign psel_o    = psel_q;
  assign penable_o = penable_q;
  assign paddr_o   = {op_addr_i.flat[ADDR_WIDTH-1:OFFSET_WIDTH], word_sel, 2'b00};
  assign pwrite_o  = (op_kind_i == OP_WRITEBACK) || (is_bypass && op_we_i);
  assign pwdata_o  = (op_kind_i == OP_WRITEBACK) ? op_line_i[cnt_q*WORD_WIDTH +: WORD_WIDTH]
                                                 : op_wdata_i;
  assign pstrb_o   = (op_kind_i == OP_WRITEBACK) ? '1 :
                     (is_bypass && op_we_i)       ? op_be_i : '0;

  assign op_done_o   = done_q;
  assign done_line_o = line_q;
  // bypass data lands in word 0 since the counter stays at zero
  assign done_word_o = line_q[WORD_WIDTH-1:0];

  // setup, access, then the next word or done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      psel_q    <= 1'b0;
      penable_q <= 1'b0;
      done_q    <= 1'b0;
      cnt_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (!psel_q) begin
        // skip the op that is just being retired
        if (op_valid_i && !done_q) begin
          psel_q <= 1'b1;
          cnt_q  <= '0;
        end
      end else if (!penable_q) begin
        penable_q <= 1'b1;
      end else if (pready_i) begin
        penable_q <= 1'b0;
        if (last) begin
          psel_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // read data collected per word
  always_ff @(posedge clk_i) begin
    if (psel_q && penable_q && pready_i) begin
      line_q[cnt_q*WORD_WIDTH +: WORD_WIDTH] <= prdata_i;
    end
  end

  // address and direction hold until the transfer completes
  a_apb_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_o && !(penable_o && pready_i)) |=> ($stable(paddr_o) && $stable(pwrite_o)));

endmodule

// File: dcache_ctrl.sv
// ----------------------------------------------------------
// request FSM: lookup, hit response, store merge, miss and bypass
// ----------------------------------------------------------
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter int NUM_WAYS = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // core port
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  dcache_pkg::cache_addr_u              addr_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]    wdata_i,
  input  logic [dcache_pkg::BE_WIDTH-1:0]      be_i,
  output logic                                 gnt_o,
  output logic                                 rvalid_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]    rdata_o,
  // array control
  output logic                                 arr_rd_en_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]   arr_rd_index_o,
  output logic                                 arr_wr_en_o,
  output logic [NUM_WAYS-1:0]                  arr_wr_way_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]   arr_wr_index_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]     arr_wr_tag_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]    arr_wr_line_o,
  output logic [dcache_pkg::LINE_BE_WIDTH-1:0] arr_wr_line_be_o,
  output logic                                 arr_wr_dirty_o,
  // array status
  input  logic                                 arr_hit_i,
  input  logic [NUM_WAYS-1:0]                  arr_hit_way_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]    arr_hit_line_i,
  input  logic [NUM_WAYS-1:0]                  arr_victim_way_i,
  input  logic                                 arr_victim_dirty_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]     arr_victim_tag_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]    arr_victim_line_i,
  // refill unit
  output logic                                 op_valid_o,
  output dcache_pkg::op_kind_e                 op_kind_o,
  output dcache_pkg::cache_addr_u              op_addr_o,
  output logic [dcache_pkg::LINE_WIDTH-1:0]    op_line_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]    op_wdata_o,
  output logic [dcache_pkg::BE_WIDTH-1:0]      op_be_o,
  output logic                                 op_we_o,
  input  logic                                 op_done_i,
  input  logic [dcache_pkg::LINE_WIDTH-1:0]    done_line_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]    done_word_i
);
  import dcache_pkg::*;

  ctrl_state_e               state_d, state_q;
  ctrl_state_e               accept_state;
  logic                      accept;
  // saved request
  logic                      req_we_q;
  cache_addr_u               req_addr_q;
  logic [WORD_WIDTH-1:0]     req_wdata_q;
  logic [BE_WIDTH-1:0]       req_be_q;
  logic [WORD_SEL_WIDTH-1:0] word_sel;

  assign word_sel     = req_addr_q.f.offset[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
  // uncacheable requests go straight to the APB bypass
  assign accept_state = ((addr_i.flat & UNCACHED_BASE) != '0) ? S_BYPASS : S_LOOKUP;

  // the saved tag also drives the lookup compare
  assign arr_wr_index_o = req_addr_q.f.index;
  assign arr_wr_tag_o   = req_addr_q.f.tag;
  assign arr_rd_index_o = accept ? addr_i.f.index : req_addr_q.f.index;

  // ----------------------------------------------------------
  // refill unit request
  // ----------------------------------------------------------
  assign op_valid_o = (state_q == S_WRITEBACK) || (state_q == S_REFILL) || (state_q == S_BYPASS);
  assign op_kind_o  = (state_q == S_WRITEBACK) ? OP_WRITEBACK :
                      (state_q == S_REFILL)    ? OP_REFILL : OP_BYPASS;
  // writeback goes to the victim's line address
  assign op_addr_o  = (state_q == S_WRITEBACK)
                    ? {arr_victim_tag_i, req_addr_q.f.index, {OFFSET_WIDTH{1'b0}}}
                    : req_addr_q.flat;
  assign op_line_o  = arr_victim_line_i;
  assign op_wdata_o = req_wdata_q;
  assign op_be_o    = req_be_q;
  assign op_we_o    = req_we_q;

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d          = state_q;
    accept           = 1'b0;
    gnt_o            = 1'b0;
    rvalid_o         = 1'b0;
    rdata_o          = arr_hit_line_i[word_sel*WORD_WIDTH +: WORD_WIDTH];
    arr_rd_en_o      = 1'b0;
    arr_wr_en_o      = 1'b0;
    arr_wr_way_o     = arr_hit_way_i;
    // store word copied to every slot, the byte enables pick the one
    arr_wr_line_o    = {WORDS_PER_LINE{req_wdata_q}};
    arr_wr_line_be_o = '0;
    arr_wr_dirty_o   = 1'b1;

    case (state_q)
      S_IDLE: begin
        accept = req_i;
      end
      S_LOOKUP: begin
        if (arr_hit_i) begin
          if (req_we_q) begin
            state_d = S_STORE;
          end else begin
            // load hit, take the next request in the same cycle
            rvalid_o = 1'b1;
            state_d  = S_IDLE;
            accept   = req_i;
          end
        end else begin
          state_d = arr_victim_dirty_i ? S_WRITEBACK : S_REFILL;
        end
      end
      S_STORE: begin
        // merge under byte enables and mark dirty
        arr_wr_en_o      = 1'b1;
        arr_wr_line_be_o = LINE_BE_WIDTH'(req_be_q) << (word_sel * BE_WIDTH);
        state_d          = S_IDLE;
      end
      S_WRITEBACK: begin
        if (op_done_i) begin
          state_d = S_REFILL;
        end
      end
      S_REFILL: begin
        if (op_done_i) begin
          // install the clean line in the victim way
          arr_wr_en_o      = 1'b1;
          arr_wr_way_o     = arr_victim_way_i;
          arr_wr_line_o    = done_line_i;
          arr_wr_line_be_o = '1;
          arr_wr_dirty_o   = 1'b0;
          state_d          = S_REPLAY;
        end
      end
      S_REPLAY: begin
        arr_rd_en_o = 1'b1;
        state_d     = S_LOOKUP;
      end
      S_BYPASS: begin
        rdata_o = done_word_i;
        if (op_done_i) begin
          rvalid_o = !req_we_q;
          state_d  = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase

    // accepted request starts its tag read now
    if (accept) begin
      gnt_o       = 1'b1;
      arr_rd_en_o = 1'b1;
      state_d     = accept_state;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_q    <= we_i;
      req_addr_q  <= addr_i;
      req_wdata_q <= wdata_i;
      req_be_q    <= be_i;
    end
  end

  // no grant while the refill unit owns the request
  a_gnt_vs_op : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(gnt_o && op_valid_o));

  // op request is held steady until the refill unit answers
  a_op_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_valid_o && !op_done_i) |=> (op_valid_o && $stable(op_kind_o) && $stable(op_addr_o)
                                    && $stable(op_line_o) && $stable(op_wdata_o)));

endmodule

// File: dcache_top.sv
// ----------------------------------------------------------
// data cache top level with controller, array and APB unit
// ----------------------------------------------------------
`timescale 1ns/1ps

module dcache_top #(
  parameter int NUM_WAYS = 2
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // core port
  input  logic                               req_i,
  input  logic                               we_i,
  input  dcache_pkg::cache_addr_u            addr_i,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]  wdata_i,
  input  logic [dcache_pkg::BE_WIDTH-1:0]    be_i,
  output logic                               gnt_o,
  output logic                               rvalid_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]  rdata_o,
  // APB memory port
  output logic [dcache_pkg::ADDR_WIDTH-1:0]  paddr_o,
  output logic                               psel_o,
  output logic                               penable_o,
  output logic                               pwrite_o,
  output logic [dcache_pkg::WORD_WIDTH-1:0]  pwdata_o,
  output logic [dcache_pkg::BE_WIDTH-1:0]    pstrb_o,
  input  logic [dcache_pkg::WORD_WIDTH-1:0]  prdata_i,
  input  logic                               pready_i
);
  import dcache_pkg::*;

  // controller to array
  logic                      rd_en;
  logic [INDEX_WIDTH-1:0]    rd_index;
  logic                      wr_en;
  logic [NUM_WAYS-1:0]       wr_way;
  logic [INDEX_WIDTH-1:0]    wr_index;
  logic [TAG_WIDTH-1:0]      wr_tag;
  logic [LINE_WIDTH-1:0]     wr_line;
  logic [LINE_BE_WIDTH-1:0]  wr_line_be;
  logic                      wr_dirty;
  // array to controller
  logic                      hit;
  logic [NUM_WAYS-1:0]       hit_way;
  logic [LINE_WIDTH-1:0]     hit_line;
  logic [NUM_WAYS-1:0]       victim_way;
  logic                      victim_dirty;
  logic [TAG_WIDTH-1:0]      victim_tag;
  logic [LINE_WIDTH-1:0]     victim_line;
  // controller to refill unit
  logic                      op_valid;
  op_kind_e                  op_kind;
  cache_addr_u               op_addr;
  logic [LINE_WIDTH-1:0]     op_line;
  logic [WORD_WIDTH-1:0]     op_wdata;
  logic [BE_WIDTH-1:0]       op_be;
  logic                      op_we;
  logic                      op_done;
  logic [LINE_WIDTH-1:0]     done_line;
  logic [WORD_WIDTH-1:0]     done_word;

  dcache_ctrl #(
    .NUM_WAYS(NUM_WAYS)
  ) u_ctrl (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o, .rvalid_o, .rdata_o,
    .arr_rd_en_o(rd_en), .arr_rd_index_o(rd_index), .arr_wr_en_o(wr_en),
    .arr_wr_way_o(wr_way), .arr_wr_index_o(wr_index), .arr_wr_tag_o(wr_tag),
    .arr_wr_line_o(wr_line), .arr_wr_line_be_o(wr_line_be), .arr_wr_dirty_o(wr_dirty),
    .arr_hit_i(hit), .arr_hit_way_i(hit_way), .arr_hit_line_i(hit_line),
    .arr_victim_way_i(victim_way), .arr_victim_dirty_i(victim_dirty),
    .arr_victim_tag_i(victim_tag), .arr_victim_line_i(victim_line),
    .op_valid_o(op_valid), .op_kind_o(op_kind), .op_addr_o(op_addr), .op_line_o(op_line),
    .op_wdata_o(op_wdata), .op_be_o(op_be), .op_we_o(op_we),
    .op_done_i(op_done), .done_line_i(done_line), .done_word_i(done_word)
  );

  // lookup compares against the saved request tag
  dcache_array #(
    .NUM_WAYS(NUM_WAYS)
  ) u_array (
    .clk_i, .rst_ni, .rd_en_i(rd_en), .rd_index_i(rd_index), .lookup_tag_i(wr_tag),
    .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_index_i(wr_index), .wr_tag_i(wr_tag),
    .wr_line_i(wr_line), .wr_line_be_i(wr_line_be), .wr_dirty_i(wr_dirty),
    .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line), .victim_way_o(victim_way),
    .victim_dirty_o(victim_dirty), .victim_tag_o(victim_tag), .victim_line_o(victim_line)
  );

  dcache_refill u_refill (
    .clk_i, .rst_ni, .op_valid_i(op_valid), .op_kind_i(op_kind), .op_addr_i(op_addr),
    .op_line_i(op_line), .op_wdata_i(op_wdata), .op_be_i(op_be), .op_we_i(op_we),
    .op_done_o(op_done), .done_line_o(done_line), .done_word_o(done_word),
    .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o, .pstrb_o, .prdata_i, .pready_i
  );

endmodule

// File: tb_clk_gen.sv
// ----------------------------------------------------------
// testbench clock and reset source
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);
  always begin
    clk_o = 1'b0;
    #(PERIOD_NS / 2);
    clk_o = 1'b1;
    #(PERIOD_NS / 2);
  end

  // reset drops on a falling edge, clear of the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end
endmodule

// File: tb_dcache.sv
// ----------------------------------------------------------
// random load/store test with APB memory and cache model
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_dcache;
  import dcache_pkg::*;

  localparam int NUM_WAYS     = 2;
  localparam int NUM_REQ      = 600;
  localparam int CYCLE_LIMIT  = NUM_REQ * 60 + 200;
  localparam int SETS         = 16;
  // 3 tags over all sets, then 16 uncached words
  localparam int CACHED_WORDS = 3 * SETS * WORDS_PER_LINE;
  localparam int MEM_WORDS    = CACHED_WORDS + 16;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  req_i;
  logic                  we_i;
  cache_addr_u           addr_i;
  logic [WORD_WIDTH-1:0] wdata_i;
  logic [BE_WIDTH-1:0]   be_i;
  logic                  gnt_o;
  logic                  rvalid_o;
  logic [WORD_WIDTH-1:0] rdata_o;
  logic [ADDR_WIDTH-1:0] paddr_o;
  logic                  psel_o;
  logic                  penable_o;
  logic                  pwrite_o;
  logic [WORD_WIDTH-1:0] pwdata_o;
  logic [BE_WIDTH-1:0]   pstrb_o;
  logic [WORD_WIDTH-1:0] prdata_i;
  logic                  pready_i;

  integer                seed;
  int                    err_value;
  int                    err_other;
  int                    cycles;
  int                    issued;
  int                    wait_left;
  logic                  granted;
  logic                  req_active;
  logic                  hit_due;
  logic                  finished;
  // APB hold tracking between setup and completion
  logic                  apb_hold;
  logic [ADDR_WIDTH-1:0] hold_addr;
  logic                  hold_write;
  logic [WORD_WIDTH-1:0] hold_wdata;
  // memory behind APB and the value each load must see
  logic [WORD_WIDTH-1:0] mem     [MEM_WORDS];
  logic [WORD_WIDTH-1:0] ref_mem [MEM_WORDS];
  // cache model
  logic [TAG_WIDTH-1:0]  m_tag   [NUM_WAYS][SETS];
  logic                  m_valid [NUM_WAYS][SETS];
  logic                  m_dirty [NUM_WAYS][SETS];
  int                    m_rr    [SETS];
  // expected load data and expected APB transfers {write, strb, wdata, addr}
  logic [WORD_WIDTH-1:0] load_q [$];
  logic [68:0]           apb_q  [$];

  tb_clk_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  dcache_top #(
    .NUM_WAYS(NUM_WAYS)
  ) u_dcache_top (
    .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .gnt_o, .rvalid_o, .rdata_o,
    .paddr_o, .psel_o, .penable_o, .pwrite_o, .pwdata_o, .pstrb_o, .prdata_i, .pready_i
  );

  function automatic int mem_idx(input logic [ADDR_WIDTH-1:0] a);
    int idx;
    if ((a & UNCACHED_BASE) != '0) begin
      idx = CACHED_WORDS + int'(a[5:2]);
    end else begin
      idx = int'(a[9:2]);
    end
    return idx;
  endfunction

  function automatic logic [WORD_WIDTH-1:0] merge_bytes(input logic [WORD_WIDTH-1:0] old_word,
                                                        input logic [WORD_WIDTH-1:0] new_word,
                                                        input logic [BE_WIDTH-1:0]   be);
    logic [WORD_WIDTH-1:0] res;
    res = old_word;
    for (int b = 0; b < BE_WIDTH; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      err_value++;
      $display("Fail at %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_other++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic push_apb(input logic wr, input logic [3:0] strb, input logic [31:0] wdata,
                          input logic [31:0] addr);
    apb_q.push_back({wr, strb, wdata, addr});
  endtask

  // ----------------------------------------------------------
  // model update at grant time
  // ----------------------------------------------------------
  task automatic model_request();
    int                    idx;
    int                    set;
    int                    way;
    logic [ADDR_WIDTH-1:0] base;
    logic [ADDR_WIDTH-1:0] waddr;
    idx = mem_idx(addr_i.flat);
    set = int'(addr_i.f.index);
    way = -1;
    if (!we_i) begin
      load_q.push_back(ref_mem[idx]);
    end else begin
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdata_i, be_i);
    end
    if ((addr_i.flat & UNCACHED_BASE) != '0) begin
      // one word over APB, never allocated
      push_apb(we_i, we_i ? be_i : 4'h0, wdata_i, {addr_i.flat[ADDR_WIDTH-1:2], 2'b00});
    end else begin
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (m_valid[w][set] && (m_tag[w][set] == addr_i.f.tag)) begin
          way = w;
        end
      end
      if (way >= 0) begin
        if (we_i) begin
          m_dirty[way][set] = 1'b1;
        end else begin
          hit_due = 1'b1;
        end
      end else begin
        // lowest free way first, round robin otherwise
        way = m_rr[set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
          if (!m_valid[w][set]) begin
            way = w;
          end
        end
        if (m_valid[way][set] && m_dirty[way][set]) begin
          base = {m_tag[way][set], addr_i.f.index, 4'h0};
          for (int w = 0; w < WORDS_PER_LINE; w++) begin
            waddr = base + ADDR_WIDTH'(w * 4);
            push_apb(1'b1, 4'hf, ref_mem[mem_idx(waddr)], waddr);
          end
        end
        base = {addr_i.f.tag, addr_i.f.index, 4'h0};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          push_apb(1'b0, 4'h0, 32'h0, base + ADDR_WIDTH'(w * 4));
        end
        m_tag[way][set]   = addr_i.f.tag;
        m_valid[way][set] = 1'b1;
        m_dirty[way][set] = we_i;
        m_rr[set]         = (m_rr[set] + 1) % NUM_WAYS;
      end
    end
  endtask

  // ----------------------------------------------------------
  // end of cycle: protocol checks, responses, grants
  // ----------------------------------------------------------
  task automatic sample_cycle();
    logic [68:0] exp;
    logic        xfer;
    logic        due;
    int          idx;
    xfer    = psel_o && penable_o && pready_i;
    due     = hit_due;
    hit_due = 1'b0;
    granted = gnt_o;
    if (apb_hold) begin
      if (!(psel_o && penable_o)) begin
        report_error("APB transfer left before pready");
      end
      check_equal(paddr_o, hold_addr, "paddr held during transfer");
      check_equal(32'(pwrite_o), 32'(hold_write), "pwrite held during transfer");
      check_equal(pwdata_o, hold_wdata, "pwdata held during transfer");
    end else if (psel_o && penable_o) begin
      report_error("APB access phase without a setup phase");
    end
    apb_hold   = psel_o && !xfer;
    hold_addr  = paddr_o;
    hold_write = pwrite_o;
    hold_wdata = pwdata_o;
    // 0 to 3 wait states, drawn in the setup phase
    if (psel_o && !penable_o) begin
      wait_left = $unsigned($random(seed)) % 4;
    end else if (psel_o && penable_o && !pready_i && wait_left > 0) begin
      wait_left--;
    end
    if (xfer) begin
      if (apb_q.size() == 0) begin
        report_error("APB transfer that no request explains");
      end else begin
        exp = apb_q.pop_front();
        check_equal(paddr_o, exp[31:0], "APB address");
        check_equal(32'(pwrite_o), 32'(exp[68]), "APB direction");
        check_equal(32'(pstrb_o), 32'(exp[67:64]), "APB strobes");
        if (exp[68]) begin
          check_equal(pwdata_o, exp[63:32], "APB write data");
        end
      end
      if (pwrite_o) begin
        idx      = mem_idx(paddr_o);
        mem[idx] = merge_bytes(mem[idx], pwdata_o, pstrb_o);
      end
    end
    if (due) begin
      check_equal(32'(rvalid_o), 32'd1, "rvalid one cycle after a load hit grant");
      check_equal(32'(psel_o), 32'd0, "no APB traffic during a load hit");
      if (req_i) begin
        check_equal(32'(gnt_o), 32'd1, "next request granted with the hit rvalid");
      end
    end
    if (rvalid_o) begin
      if (load_q.size() == 0) begin
        report_error("rvalid with no load outstanding");
      end else begin
        check_equal(rdata_o, load_q.pop_front(), "load data");
      end
    end
    if (gnt_o) begin
      if (!req_i) begin
        report_error("grant without a request");
      end else begin
        model_request();
      end
    end
  endtask

  // ----------------------------------------------------------
  // falling edge: memory response and next request
  // ----------------------------------------------------------
  task automatic drive_cycle();
    logic [31:0] r;
    if (granted) begin
      req_active = 1'b0;
    end
    pready_i = psel_o && penable_o && (wait_left == 0);
    prdata_i = psel_o ? mem[mem_idx(paddr_o)] : '0;
    // an idle cycle now and then between requests
    if (!req_active && issued < NUM_REQ && ($unsigned($random(seed)) % 8 != 0)) begin
      r       = $random(seed);
      we_i    = r[0];
      be_i    = r[4:1];
      wdata_i = $random(seed);
      if (r[7:5] == 3'd0) begin
        addr_i.flat = UNCACHED_BASE | {26'd0, r[11:8], 2'b00};
      end else begin
        addr_i.flat     = '0;
        addr_i.f.tag    = TAG_WIDTH'(r[13:12] % 2'd3);
        addr_i.f.index  = r[17:14];
        addr_i.f.offset = {r[19:18], 2'b00};
      end
      req_active = 1'b1;
      issued++;
    end
    req_i = req_active;
  endtask

  initial begin
    seed      = 32'ha920;
    err_value = 0;
    err_other = 0;
    cycles    = 0;
    issued    = 0;
    wait_left = 0;
    granted   = 1'b0;
    req_active = 1'b0;
    hit_due   = 1'b0;
    finished  = 1'b0;
    apb_hold  = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    be_i      = '0;
    prdata_i  = '0;
    pready_i  = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = $random(seed);
      ref_mem[i] = mem[i];
    end
    for (int s = 0; s < SETS; s++) begin
      m_rr[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
      end
    end
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    while (!finished && cycles < CYCLE_LIMIT) begin
      // sample just before the rising edge, where all outputs have settled
      #9;
      sample_cycle();
      @(negedge clk_i);
      drive_cycle();
      cycles++;
      finished = (issued == NUM_REQ) && !req_active && (load_q.size() == 0)
                 && (apb_q.size() == 0) && !psel_o;
    end
    if (!finished) begin
      report_error($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
    end else begin
      // a few quiet cycles to catch stray responses
      repeat (4) begin
        #9;
        sample_cycle();
        @(negedge clk_i);
        drive_cycle();
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end
endmodule

// File: sources.f
dcache_pkg.sv
dcache_array.sv
dcache_refill.sv
dcache_ctrl.sv
dcache_top.sv
tb_clk_gen.sv
tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
set -o pipefail

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_dcache -o Vtb_dcache
./obj_dir/Vtb_dcache | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
